// ==== cpuControl.f ====
hdl/cpuCtrlPkg.sv
hdl/excIf.sv
hdl/stateSequencer.sv
hdl/exceptionUnit.sv
hdl/controlDecode.sv
hdl/cpuControl.sv
tb/cpuControl_asserts.sv
tb/cpuControlTb.sv

// ==== Bender.yml ====
package:
  name: cpu_control

sources:
  - files:
      - hdl/cpuCtrlPkg.sv
      - hdl/excIf.sv
      - hdl/stateSequencer.sv
      - hdl/exceptionUnit.sv
      - hdl/controlDecode.sv
      - hdl/cpuControl.sv
  - target: test
    files:
      - tb/cpuControl_asserts.sv
      - tb/cpuControlTb.sv

// ==== tb/cpuControlTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuControlTb;

	localparam int dataWidth     = 16;
	localparam int numRows       = 25;
	localparam int handlerCycles = 4;
	localparam int watchdogTime  = (numRows * 16 + 20) * 8;

	// one row of stimulus and its expected outcome
	typedef struct packed {
		cpuCtrlPkg::opcodeT   op;
		logic                 ovfl;
		logic                 accInv;
		logic                 misalign;
		logic                 inputRecv;
		logic [dataWidth-1:0] bread;
		logic [3:0]           expCycles;
		logic                 hasType;
		logic [1:0]           expType;
	} rowT;

	logic CLK;
	logic Reset;
	cpuCtrlPkg::opcodeT op;
	logic [dataWidth-1:0] bread;
	logic ovfl;
	logic AccInv;
	logic Misalign;
	logic InputRecv;
	logic ReadAddr;
	logic IRWrite;
	logic [cpuCtrlPkg::aluASelW-1:0] ALUA;
	logic [cpuCtrlPkg::aluBSelW-1:0] ALUB;
	logic [cpuCtrlPkg::aluCtrlW-1:0] ALUControl;
	logic [cpuCtrlPkg::pcSrcW-1:0] PCSource;
	logic PCWrite;
	logic PCWriteCond;
	logic RegWrite;
	logic MemWrite;
	logic AWrite;
	logic BWrite;
	logic CWrite;
	logic [cpuCtrlPkg::shiftSelW-1:0] ShifterInput;
	logic [cpuCtrlPkg::shiftSelW-1:0] ShifterControl;
	logic ShifterLeft;
	logic [cpuCtrlPkg::regSelW-1:0] RegRead;
	logic RegRead2;
	logic ALUOutWrite;
	logic [cpuCtrlPkg::regSelW-1:0] RegDest;
	logic [cpuCtrlPkg::memToRegW-1:0] MemToReg;
	logic MDWrite;
	logic InputRst;
	logic [1:0] ExType;
	logic KernelMode;

	rowT rows [numRows];
	int errors = 0;
	int checks = 0;
	integer seed = 32'hac37;

	cpuControl #(
		.dataWidth (dataWidth)
	) i_cpuControl (
		.CLK (CLK), .Reset (Reset), .op (op), .bread (bread), .ovfl (ovfl),
		.AccInv (AccInv), .Misalign (Misalign), .InputRecv (InputRecv),
		.ReadAddr (ReadAddr), .IRWrite (IRWrite), .ALUA (ALUA), .ALUB (ALUB),
		.ALUControl (ALUControl), .PCSource (PCSource), .PCWrite (PCWrite),
		.PCWriteCond (PCWriteCond), .RegWrite (RegWrite), .MemWrite (MemWrite),
		.AWrite (AWrite), .BWrite (BWrite), .CWrite (CWrite),
		.ShifterInput (ShifterInput), .ShifterControl (ShifterControl),
		.ShifterLeft (ShifterLeft), .RegRead (RegRead), .RegRead2 (RegRead2),
		.ALUOutWrite (ALUOutWrite), .RegDest (RegDest), .MemToReg (MemToReg),
		.MDWrite (MDWrite), .InputRst (InputRst), .ExType (ExType),
		.KernelMode (KernelMode)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Fetch-to-Fetch length of an instruction that raises nothing
	function automatic int instrCycles(input cpuCtrlPkg::opcodeT code);
		case (code)
			cpuCtrlPkg::opLw:
				return 8;
			cpuCtrlPkg::opBer, cpuCtrlPkg::opRst, cpuCtrlPkg::opSw,
			cpuCtrlPkg::opLc, cpuCtrlPkg::opAddc, cpuCtrlPkg::opSpc:
				return 5;
			default:
				return 4;
		endcase
	endfunction

	function automatic logic [dataWidth-1:0] enableMask(input logic [1:0] cause);
		return 16'h1 << (cpuCtrlPkg::excEnableBase + cause);
	endfunction

	function automatic rowT makeRow(input cpuCtrlPkg::opcodeT code, input logic ov,
		input logic acc, input logic mis, input logic inp, input logic [dataWidth-1:0] br,
		input int cyc, input logic hasT, input logic [1:0] typ);
		rowT r;
		r = '{code, ov, acc, mis, inp, br, cyc[3:0], hasT, typ};
		return r;
	endfunction

	task automatic checkEqual(input string name, input int row, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("FAILED %s (row %0d): got 0x%h, expected 0x%h", name, row, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////
	task automatic buildTable;
		logic [31:0] randWord;
		cpuCtrlPkg::opcodeT code;
		// every opcode once with all flags idle
		for (int k = 0; k < 16; k++)
		begin
			code = cpuCtrlPkg::opcodeT'(k[3:0]);
			rows[k] = makeRow(code, 0, 0, 0, 0, '0, instrCycles(code), 0, 2'd0);
		end
		// overflow trapped, then rst back to user mode, then overflow disabled
		rows[16] = makeRow(cpuCtrlPkg::opAdd, 1, 0, 0, 0, enableMask(cpuCtrlPkg::causeOvfl),
			3 + handlerCycles, 1, cpuCtrlPkg::causeOvfl);
		rows[17] = makeRow(cpuCtrlPkg::opRst, 0, 0, 0, 0, '0, 5, 0, 2'd0);
		rows[18] = makeRow(cpuCtrlPkg::opAdd, 1, 0, 0, 0, ~enableMask(cpuCtrlPkg::causeOvfl),
			3 + 1 + 1, 1, cpuCtrlPkg::causeOvfl);
		// access invalid beats misalignment in Fetch
		rows[19] = makeRow(cpuCtrlPkg::opSub, 0, 1, 1, 0, enableMask(cpuCtrlPkg::causeAccInv),
			1 + handlerCycles, 1, cpuCtrlPkg::causeAccInv);
		rows[20] = makeRow(cpuCtrlPkg::opAnd, 0, 0, 1, 0,
			enableMask(cpuCtrlPkg::causeMisalign), 1 + handlerCycles, 1,
			cpuCtrlPkg::causeMisalign);
		// pending input trapped at the end of a 4-cycle instruction
		rows[21] = makeRow(cpuCtrlPkg::opAdd, 0, 0, 0, 1, enableMask(cpuCtrlPkg::causeInput),
			4 + handlerCycles, 1, cpuCtrlPkg::causeInput);
		rows[22] = makeRow(cpuCtrlPkg::opRst, 0, 0, 0, 0, '0, 5, 0, 2'd0);
		for (int k = 23; k < numRows; k++)
		begin
			randWord = $random(seed);
			code = cpuCtrlPkg::opcodeT'(randWord[3:0]);
			rows[k] = makeRow(code, 0, 0, 0, 0, '0, instrCycles(code), 0, 2'd0);
		end
	endtask

	initial
	begin
		int cycles;
		logic sawInputRst;
		logic kmModel;
		Reset     = 1'b1;
		op        = cpuCtrlPkg::opAnd;
		bread     = '0;
		ovfl      = 1'b0;
		AccInv    = 1'b0;
		Misalign  = 1'b0;
		InputRecv = 1'b0;
		kmModel   = 1'b0;
		buildTable();

		repeat (5) @(negedge CLK);
		Reset = 1'b0;
		// still in ResetState here
		checkEqual("PCSource", -1, PCSource, 16'd4);
		checkEqual("PCWrite", -1, PCWrite, 16'd1);
		checkEqual("IRWrite", -1, IRWrite, 16'd0);
		checkEqual("ExType", -1, ExType, 16'd0);
		checkEqual("KernelMode", -1, KernelMode, 16'd0);
		// every other control output idle in ResetState
		checkEqual("ReadAddr", -1, ReadAddr, 16'd0);
		checkEqual("ALUA", -1, ALUA, 16'd0);
		checkEqual("ALUB", -1, ALUB, 16'd0);
		checkEqual("ALUControl", -1, ALUControl, 16'd0);
		checkEqual("PCWriteCond", -1, PCWriteCond, 16'd0);
		checkEqual("RegWrite", -1, RegWrite, 16'd0);
		checkEqual("MemWrite", -1, MemWrite, 16'd0);
		checkEqual("AWrite", -1, AWrite, 16'd0);
		checkEqual("BWrite", -1, BWrite, 16'd0);
		checkEqual("CWrite", -1, CWrite, 16'd0);
		checkEqual("ShifterInput", -1, ShifterInput, 16'd0);
		checkEqual("ShifterControl", -1, ShifterControl, 16'd0);
		checkEqual("ShifterLeft", -1, ShifterLeft, 16'd0);
		checkEqual("RegRead", -1, RegRead, 16'd0);
		checkEqual("RegRead2", -1, RegRead2, 16'd0);
		checkEqual("ALUOutWrite", -1, ALUOutWrite, 16'd0);
		checkEqual("RegDest", -1, RegDest, 16'd0);
		checkEqual("MemToReg", -1, MemToReg, 16'd0);
		checkEqual("MDWrite", -1, MDWrite, 16'd0);
		checkEqual("InputRst", -1, InputRst, 16'd0);
		@(negedge CLK);
		checkEqual("IRWrite", -1, IRWrite, 16'd1);

		//////////////////////////////////////////////////////////////
		// one row per instruction, applied in the Fetch cycle
		//////////////////////////////////////////////////////////////
		for (int i = 0; i < numRows; i++)
		begin
			op          = rows[i].op;
			ovfl        = rows[i].ovfl;
			AccInv      = rows[i].accInv;
			Misalign    = rows[i].misalign;
			InputRecv   = rows[i].inputRecv;
			bread       = rows[i].bread;
			cycles      = 0;
			sawInputRst = 1'b0;
			do
			begin
				@(negedge CLK);
				cycles++;
				if (InputRst)
				begin
					sawInputRst = 1'b1;
					InputRecv   = 1'b0;
				end
				if (PCSource == 3'd3)
				begin
					// handler running, flags have done their job
					checkEqual("KernelMode", i, KernelMode, 16'd1);
					ovfl      = 1'b0;
					AccInv    = 1'b0;
					Misalign  = 1'b0;
					InputRecv = 1'b0;
				end
			end
			while (!IRWrite);

			if (rows[i].hasType)
				kmModel = 1'b1;
			else if (rows[i].op == cpuCtrlPkg::opRst)
				kmModel = 1'b0;
			checkEqual("cycles", i, cycles, rows[i].expCycles);
			if (rows[i].hasType)
				checkEqual("ExType", i, ExType, rows[i].expType);
			checkEqual("KernelMode", i, KernelMode, kmModel);
			if (rows[i].inputRecv)
			begin
				checks++;
				assert (sawInputRst)
				else
				begin
					errors++;
					$display("row %0d: input exception taken but InputRst never pulsed", i);
				end
			end
		end

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(watchdogTime);
		$display("timeout after %0d ns, the DUT never returned to Fetch", watchdogTime);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/cpuControl_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuControlAsserts (
	input logic                          CLK,
	input logic                          Reset,
	input logic                          IRWrite,
	input logic                          PCWrite,
	input logic                          MemWrite,
	input logic                          ReadAddr,
	input logic [cpuCtrlPkg::pcSrcW-1:0] PCSource,
	input logic                          KernelMode
);

	// every Fetch also advances the PC
	irImpliesPc: assert property (@(posedge CLK) disable iff (Reset)
		IRWrite |-> PCWrite)
		else $error("IRWrite high without PCWrite");

	// a store always drives the memory address
	storeHasAddr: assert property (@(posedge CLK) disable iff (Reset)
		MemWrite |-> ReadAddr)
		else $error("MemWrite high without ReadAddr");

	// jump to the handler vector only in kernel mode
	vectorInKernel: assert property (@(posedge CLK) disable iff (Reset)
		(PCSource == 3'd3) |-> (PCWrite && KernelMode))
		else $error("handler vector selected without PCWrite or outside kernel mode");

endmodule

bind cpuControl cpuControlAsserts i_cpuControlAsserts (
	.CLK        (CLK),
	.Reset      (Reset),
	.IRWrite    (IRWrite),
	.PCWrite    (PCWrite),
	.MemWrite   (MemWrite),
	.ReadAddr   (ReadAddr),
	.PCSource   (PCSource),
	.KernelMode (KernelMode)
);

`default_nettype wire

// ==== hdl/cpuControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuControl #(
	parameter int dataWidth = 16
) (
	input  logic                                  CLK,
	input  logic                                  Reset,
	input  cpuCtrlPkg::opcodeT                    op,
	input  logic [dataWidth-1:0]                  bread,
	input  logic                                  ovfl,
	input  logic                                  AccInv,
	input  logic                                  Misalign,
	input  logic                                  InputRecv,
	output logic                                  ReadAddr,
	output logic                                  IRWrite,
	output logic [cpuCtrlPkg::aluASelW-1:0]       ALUA,
	output logic [cpuCtrlPkg::aluBSelW-1:0]       ALUB,
	output logic [cpuCtrlPkg::aluCtrlW-1:0]       ALUControl,
	output logic [cpuCtrlPkg::pcSrcW-1:0]         PCSource,
	output logic                                  PCWrite,
	output logic                                  PCWriteCond,
	output logic                                  RegWrite,
	output logic                                  MemWrite,
	output logic                                  AWrite,
	output logic                                  BWrite,
	output logic                                  CWrite,
	output logic [cpuCtrlPkg::shiftSelW-1:0]      ShifterInput,
	output logic [cpuCtrlPkg::shiftSelW-1:0]      ShifterControl,
	output logic                                  ShifterLeft,
	output logic [cpuCtrlPkg::regSelW-1:0]        RegRead,
	output logic                                  RegRead2,
	output logic                                  ALUOutWrite,
	output logic [cpuCtrlPkg::regSelW-1:0]        RegDest,
	output logic [cpuCtrlPkg::memToRegW-1:0]      MemToReg,
	output logic                                  MDWrite,
	output logic                                  InputRst,
	output logic [1:0]                            ExType,
	output logic                                  KernelMode
);

	cpuCtrlPkg::ctrlStateT state;

	// sequencer to exception unit
	excIf excBus ();

	stateSequencer i_stateSequencer (
		.CLK     (CLK),
		.Reset   (Reset),
		.op      (op),
		.excPort (excBus.seq),
		.state   (state)
	);

	exceptionUnit #(
		.dataWidth (dataWidth)
	) i_exceptionUnit (
		.CLK        (CLK),
		.Reset      (Reset),
		.ovfl       (ovfl),
		.AccInv     (AccInv),
		.Misalign   (Misalign),
		.InputRecv  (InputRecv),
		.bread      (bread),
		.excPort    (excBus.exc),
		.ExType     (ExType),
		.KernelMode (KernelMode)
	);

	controlDecode i_controlDecode (
		.state          (state),
		.ReadAddr       (ReadAddr),
		.IRWrite        (IRWrite),
		.ALUA           (ALUA),
		.ALUB           (ALUB),
		.ALUControl     (ALUControl),
		.PCSource       (PCSource),
		.PCWrite        (PCWrite),
		.PCWriteCond    (PCWriteCond),
		.RegWrite       (RegWrite),
		.MemWrite       (MemWrite),
		.AWrite         (AWrite),
		.BWrite         (BWrite),
		.CWrite         (CWrite),
		.ShifterInput   (ShifterInput),
		.ShifterControl (ShifterControl),
		.ShifterLeft    (ShifterLeft),
		.RegRead        (RegRead),
		.RegRead2       (RegRead2),
		.ALUOutWrite    (ALUOutWrite),
		.RegDest        (RegDest),
		.MemToReg       (MemToReg),
		.MDWrite        (MDWrite),
		.InputRst       (InputRst)
	);

endmodule

`default_nettype wire

// ==== hdl/controlDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecode (
	input  cpuCtrlPkg::ctrlStateT                 state,
	output logic                                  ReadAddr,
	output logic                                  IRWrite,
	output logic [cpuCtrlPkg::aluASelW-1:0]       ALUA,
	output logic [cpuCtrlPkg::aluBSelW-1:0]       ALUB,
	output logic [cpuCtrlPkg::aluCtrlW-1:0]       ALUControl,
	output logic [cpuCtrlPkg::pcSrcW-1:0]         PCSource,
	output logic                                  PCWrite,
	output logic                                  PCWriteCond,
	output logic                                  RegWrite,
	output logic                                  MemWrite,
	output logic                                  AWrite,
	output logic                                  BWrite,
	output logic                                  CWrite,
	output logic [cpuCtrlPkg::shiftSelW-1:0]      ShifterInput,
	output logic [cpuCtrlPkg::shiftSelW-1:0]      ShifterControl,
	output logic                                  ShifterLeft,
	output logic [cpuCtrlPkg::regSelW-1:0]        RegRead,
	output logic                                  RegRead2,
	output logic                                  ALUOutWrite,
	output logic [cpuCtrlPkg::regSelW-1:0]        RegDest,
	output logic [cpuCtrlPkg::memToRegW-1:0]      MemToReg,
	output logic                                  MDWrite,
	output logic                                  InputRst
);

	always_comb
	begin
		// everything idle unless the state asks for it
		ReadAddr       = 1'b0;
		IRWrite        = 1'b0;
		ALUA           = 3'd0;
		ALUB           = 2'd0;
		ALUControl     = 2'd0;
		PCSource       = 3'd0;
		PCWrite        = 1'b0;
		PCWriteCond    = 1'b0;
		RegWrite       = 1'b0;
		MemWrite       = 1'b0;
		AWrite         = 1'b0;
		BWrite         = 1'b0;
		CWrite         = 1'b0;
		ShifterInput   = 2'd0;
		ShifterControl = 2'd0;
		ShifterLeft    = 1'b0;
		RegRead        = 2'd0;
		RegRead2       = 1'b0;
		ALUOutWrite    = 1'b0;
		RegDest        = 2'd0;
		MemToReg       = 2'd0;
		MDWrite        = 1'b0;
		InputRst       = 1'b0;

		case (state)
			//////////////////////////////////////////////////////////////
			// common path
			//////////////////////////////////////////////////////////////
			cpuCtrlPkg::ResetState:
			begin
				PCWrite  = 1'b1;
				PCSource = 3'd4;
			end
			cpuCtrlPkg::Fetch:
			begin
				// IR load and PC + 1 in the same cycle
				IRWrite    = 1'b1;
				ALUB       = 2'd1;
				ALUControl = 2'd1;
				PCSource   = 3'd1;
				PCWrite    = 1'b1;
			end
			cpuCtrlPkg::Decode:
			begin
				AWrite  = 1'b1;
				BWrite  = 1'b1;
				RegRead = 2'd1;
			end
			cpuCtrlPkg::R_Execution:
			begin
				ALUA        = 3'd1;
				ALUOutWrite = 1'b1;
				CWrite      = 1'b1;
			end
			// plain register writebacks
			cpuCtrlPkg::R_Write, cpuCtrlPkg::Load_Shift, cpuCtrlPkg::Lpc_Load:
				RegWrite = 1'b1;
			cpuCtrlPkg::Ber:
				PCWriteCond = 1'b1;
			//////////////////////////////////////////////////////////////
			// memory access
			//////////////////////////////////////////////////////////////
			cpuCtrlPkg::Calculate_Memory:
			begin
				ALUA           = 3'd1;
				ALUB           = 2'd2;
				ALUControl     = 2'd1;
				ALUOutWrite    = 1'b1;
				ShifterControl = 2'd2;
				ShifterLeft    = 1'b1;
				CWrite         = 1'b1;
			end
			cpuCtrlPkg::Store_Word:
			begin
				ReadAddr = 1'b1;
				MemWrite = 1'b1;
			end
			cpuCtrlPkg::Load_Word_1:
			begin
				ReadAddr = 1'b1;
				MDWrite  = 1'b1;
			end
			cpuCtrlPkg::Load_Word_2:
			begin
				MemToReg = 2'd1;
				RegWrite = 1'b1;
			end
			//////////////////////////////////////////////////////////////
			// shifts, constants and PC moves
			//////////////////////////////////////////////////////////////
			cpuCtrlPkg::Shift_L, cpuCtrlPkg::Shift_R:
			begin
				ALUA           = 3'd2;
				ALUB           = 2'd2;
				ALUControl     = 2'd1;
				ALUOutWrite    = 1'b1;
				ShifterInput   = 2'd2;
				ShifterControl = 2'd1;
				ShifterLeft    = (state == cpuCtrlPkg::Shift_L);
			end
			cpuCtrlPkg::Lpc_Calculate, cpuCtrlPkg::Spc_Calculate:
			begin
				// spc takes its base from a different ALU A source
				ALUA         = (state == cpuCtrlPkg::Spc_Calculate) ? 3'd3 : 3'd0;
				ALUB         = 2'd2;
				ALUControl   = 2'd1;
				ALUOutWrite  = 1'b1;
				ShifterInput = 2'd1;
				ShifterLeft  = 1'b1;
			end
			cpuCtrlPkg::Spc_Load:
			begin
				PCSource = 3'd2;
				PCWrite  = 1'b1;
			end
			cpuCtrlPkg::Loading_Calculations:
				CWrite = 1'b1;
			cpuCtrlPkg::LC, cpuCtrlPkg::Addc:
			begin
				ALUA           = (state == cpuCtrlPkg::Addc) ? 3'd4 : 3'd2;
				ALUB           = 2'd2;
				ALUControl     = 2'd1;
				ALUOutWrite    = 1'b1;
				ShifterInput   = 2'd1;
				ShifterControl = 2'd2;
				ShifterLeft    = 1'b1;
			end
			//////////////////////////////////////////////////////////////
			// rst and the exception handler
			//////////////////////////////////////////////////////////////
			cpuCtrlPkg::Rst_RUM:
			begin
				RegRead = 2'd2;
				AWrite  = 1'b1;
			end
			cpuCtrlPkg::Rst_Ex:
			begin
				ALUA           = 3'd5;
				ALUB           = 2'd2;
				ALUControl     = 2'd2;
				ALUOutWrite    = 1'b1;
				ShifterInput   = 2'd2;
				ShifterControl = 2'd3;
			end
			cpuCtrlPkg::RstExH_WB:
			begin
				RegDest  = 2'd2;
				RegWrite = 1'b1;
			end
			cpuCtrlPkg::ExH_B:
			begin
				// status word into B, pending input acknowledged
				BWrite   = 1'b1;
				RegRead2 = 1'b1;
				InputRst = 1'b1;
			end
			cpuCtrlPkg::ExH_PC:
			begin
				PCWrite     = 1'b1;
				PCSource    = 3'd3;
				RegWrite    = 1'b1;
				RegDest     = 2'd1;
				MemToReg    = 2'd2;
				ALUOutWrite = 1'b1;
				ALUA        = 3'd7;
				ALUControl  = 2'd2;
			end
			cpuCtrlPkg::ExH_ALU:
			begin
				ALUA           = 3'd6;
				ALUB           = 2'd2;
				ALUControl     = 2'd1;
				ALUOutWrite    = 1'b1;
				ShifterInput   = 2'd3;
				ShifterControl = 2'd3;
				ShifterLeft    = 1'b1;
			end
			// Reset_Memory_Read and the wait states drive nothing
			default:
				PCWrite = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/exceptionUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exceptionUnit #(
	parameter int dataWidth = 16
) (
	input  logic                 CLK,
	input  logic                 Reset,
	input  logic                 ovfl,
	input  logic                 AccInv,
	input  logic                 Misalign,
	input  logic                 InputRecv,
	input  logic [dataWidth-1:0] bread,
	excIf.exc                    excPort,
	output logic [1:0]           ExType,
	output logic                 KernelMode
);

	logic       causeEnabled;
	logic       aluResult;
	logic       memAccess;
	logic [1:0] cause;

	// enable bit of the latched cause, read from the status word in B
	assign causeEnabled = bread[cpuCtrlPkg::excEnableBase + ExType];

	assign excPort.skip        = (excPort.state == cpuCtrlPkg::ExH_B) && !causeEnabled;
	assign excPort.skipToWrite = (ExType == cpuCtrlPkg::causeOvfl);

	// states where each cause can be raised
	assign aluResult = (excPort.state == cpuCtrlPkg::R_Execution)
		|| (excPort.state == cpuCtrlPkg::Addc);
	assign memAccess = (excPort.state == cpuCtrlPkg::Fetch)
		|| (excPort.state == cpuCtrlPkg::Store_Word)
		|| (excPort.state == cpuCtrlPkg::Load_Word_1);

	//////////////////////////////////////////////////////////////
	// fixed priority, skip first
	//////////////////////////////////////////////////////////////
	always_comb
	begin
		excPort.take = 1'b0;
		cause = cpuCtrlPkg::causeInput;
		if (!excPort.skip)
		begin
			if (aluResult && ovfl)
			begin
				excPort.take = 1'b1;
				cause = cpuCtrlPkg::causeOvfl;
			end
			else if (memAccess && AccInv)
			begin
				excPort.take = 1'b1;
				cause = cpuCtrlPkg::causeAccInv;
			end
			else if (memAccess && Misalign)
			begin
				excPort.take = 1'b1;
				cause = cpuCtrlPkg::causeMisalign;
			end
			// pending input is only taken between instructions
			else if (excPort.nextIsFetch && InputRecv)
			begin
				excPort.take = 1'b1;
				cause = cpuCtrlPkg::causeInput;
			end
		end
	end

	always_ff @(posedge CLK or posedge Reset)
	begin
		if (Reset)
		begin
			ExType     <= cpuCtrlPkg::causeInput;
			KernelMode <= 1'b0;
		end
		else if (excPort.take)
		begin
			ExType     <= cause;
			KernelMode <= 1'b1;
		end
		else if (excPort.state == cpuCtrlPkg::Rst_RUM)
			// rst returns to user mode
			KernelMode <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hdl/stateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
	input  logic                  CLK,
	input  logic                  Reset,
	input  cpuCtrlPkg::opcodeT    op,
	excIf.seq                     excPort,
	output cpuCtrlPkg::ctrlStateT state
);

	// successor when no exception interferes
	cpuCtrlPkg::ctrlStateT nextState;

	//////////////////////////////////////////////////////////////
	// plain next-state table
	//////////////////////////////////////////////////////////////
	always_comb
	begin
		nextState = cpuCtrlPkg::Fetch;
		case (state)
			cpuCtrlPkg::Fetch:
				nextState = cpuCtrlPkg::Decode;
			cpuCtrlPkg::Decode:
			begin
				// opcode dispatch
				case (op)
					cpuCtrlPkg::opAnd, cpuCtrlPkg::opOr, cpuCtrlPkg::opNor,
					cpuCtrlPkg::opAdd, cpuCtrlPkg::opSub, cpuCtrlPkg::opSlt,
					cpuCtrlPkg::opBer:
						nextState = cpuCtrlPkg::R_Execution;
					cpuCtrlPkg::opRst:
						nextState = cpuCtrlPkg::Rst_RUM;
					cpuCtrlPkg::opLw, cpuCtrlPkg::opSw:
						nextState = cpuCtrlPkg::Calculate_Memory;
					cpuCtrlPkg::opSll:
						nextState = cpuCtrlPkg::Shift_L;
					cpuCtrlPkg::opSrl:
						nextState = cpuCtrlPkg::Shift_R;
					cpuCtrlPkg::opLc, cpuCtrlPkg::opAddc:
						nextState = cpuCtrlPkg::Loading_Calculations;
					cpuCtrlPkg::opLpc:
						nextState = cpuCtrlPkg::Lpc_Calculate;
					cpuCtrlPkg::opSpc:
						nextState = cpuCtrlPkg::Spc_Calculate;
					default:
						nextState = cpuCtrlPkg::Fetch;
				endcase
			end
			// ber shares the ALU step, then branches
			cpuCtrlPkg::R_Execution:
				nextState = (op == cpuCtrlPkg::opBer) ? cpuCtrlPkg::Ber : cpuCtrlPkg::R_Write;
			cpuCtrlPkg::Calculate_Memory:
				nextState = (op == cpuCtrlPkg::opLw) ? cpuCtrlPkg::MemoryWait
					: cpuCtrlPkg::Store_Word;
			cpuCtrlPkg::Loading_Calculations:
				nextState = (op == cpuCtrlPkg::opAddc) ? cpuCtrlPkg::Addc : cpuCtrlPkg::LC;
			// load word walks through two memory waits
			cpuCtrlPkg::MemoryWait:
				nextState = cpuCtrlPkg::Load_Word_1;
			cpuCtrlPkg::Load_Word_1:
				nextState = cpuCtrlPkg::MemoryWait2;
			cpuCtrlPkg::MemoryWait2:
				nextState = cpuCtrlPkg::Load_Word_2;
			cpuCtrlPkg::Load_Word_2, cpuCtrlPkg::Store_Word:
				nextState = cpuCtrlPkg::Reset_Memory_Read;
			cpuCtrlPkg::Shift_L, cpuCtrlPkg::Shift_R:
				nextState = cpuCtrlPkg::Load_Shift;
			cpuCtrlPkg::Lpc_Calculate:
				nextState = cpuCtrlPkg::Lpc_Load;
			cpuCtrlPkg::Spc_Calculate:
				nextState = cpuCtrlPkg::Spc_Load;
			cpuCtrlPkg::Ber, cpuCtrlPkg::Spc_Load:
				nextState = cpuCtrlPkg::WaitState;
			cpuCtrlPkg::Addc, cpuCtrlPkg::LC:
				nextState = cpuCtrlPkg::R_Write;
			cpuCtrlPkg::Rst_RUM:
				nextState = cpuCtrlPkg::Rst_Ex;
			cpuCtrlPkg::Rst_Ex, cpuCtrlPkg::ExH_ALU:
				nextState = cpuCtrlPkg::RstExH_WB;
			// handler sequence
			cpuCtrlPkg::ExH_B:
				nextState = cpuCtrlPkg::ExH_PC;
			cpuCtrlPkg::ExH_PC:
				nextState = cpuCtrlPkg::ExH_ALU;
			default:
				nextState = cpuCtrlPkg::Fetch;
		endcase
	end

	assign excPort.state       = state;
	assign excPort.nextIsFetch = (nextState == cpuCtrlPkg::Fetch);

	//////////////////////////////////////////////////////////////
	// state register
	//////////////////////////////////////////////////////////////
	always_ff @(posedge CLK or posedge Reset)
	begin
		if (Reset)
			state <= cpuCtrlPkg::ResetState;
		else if (excPort.skip)
			// disabled cause, overflow still writes its result back
			state <= excPort.skipToWrite ? cpuCtrlPkg::R_Write : cpuCtrlPkg::Fetch;
		else if (excPort.take)
			state <= cpuCtrlPkg::ExH_B;
		else
			state <= nextState;
	end

endmodule

`default_nettype wire

// ==== hdl/excIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface excIf;

	// current state and whether the plain successor would be Fetch
	cpuCtrlPkg::ctrlStateT state;
	logic                  nextIsFetch;

	// trap request and the skip path out of ExH_B
	logic take;
	logic skip;
	logic skipToWrite;

	modport seq (
		output state,
		output nextIsFetch,
		input  take,
		input  skip,
		input  skipToWrite
	);

	modport exc (
		input  state,
		input  nextIsFetch,
		output take,
		output skip,
		output skipToWrite
	);

endinterface

`default_nettype wire

// ==== hdl/cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

	//////////////////////////////////////////////////////////////
	// control states
	//////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		Fetch                = 5'd0,
		Decode               = 5'd1,
		R_Execution          = 5'd2,
		R_Write              = 5'd3,
		Ber                  = 5'd4,
		Calculate_Memory     = 5'd5,
		Store_Word           = 5'd6,
		Reset_Memory_Read    = 5'd7,
		Load_Word_1          = 5'd8,
		Load_Word_2          = 5'd9,
		Shift_L              = 5'd10,
		Shift_R              = 5'd11,
		Load_Shift           = 5'd12,
		Lpc_Calculate        = 5'd13,
		Lpc_Load             = 5'd14,
		Spc_Calculate        = 5'd15,
		Spc_Load             = 5'd16,
		Loading_Calculations = 5'd17,
		Addc                 = 5'd18,
		LC                   = 5'd19,
		Rst_RUM              = 5'd20,
		Rst_Ex               = 5'd21,
		RstExH_WB            = 5'd22,
		ExH_B                = 5'd23,
		ExH_PC               = 5'd24,
		ExH_ALU              = 5'd25,
		ResetState           = 5'd26,
		WaitState            = 5'd27,
		MemoryWait           = 5'd28,
		MemoryWait2          = 5'd29
	} ctrlStateT;

	// instruction opcodes, as found in the top nibble of the IR
	typedef enum logic [3:0] {
		opAnd  = 4'd0,
		opOr   = 4'd1,
		opNor  = 4'd2,
		opAdd  = 4'd3,
		opSub  = 4'd4,
		opSlt  = 4'd5,
		opBer  = 4'd6,
		opRst  = 4'd7,
		opLw   = 4'd8,
		opSw   = 4'd9,
		opSll  = 4'd10,
		opSrl  = 4'd11,
		opLc   = 4'd12,
		opAddc = 4'd13,
		opLpc  = 4'd14,
		opSpc  = 4'd15
	} opcodeT;

	//////////////////////////////////////////////////////////////
	// exception causes
	//////////////////////////////////////////////////////////////
	localparam logic [1:0] causeInput    = 2'd0;
	localparam logic [1:0] causeOvfl     = 2'd1;
	localparam logic [1:0] causeAccInv   = 2'd2;
	localparam logic [1:0] causeMisalign = 2'd3;

	// enable bit of cause n sits at excEnableBase + n in the status word
	localparam int excEnableBase = 4;

	// datapath select widths
	localparam int aluASelW  = 3;
	localparam int aluBSelW  = 2;
	localparam int aluCtrlW  = 2;
	localparam int pcSrcW    = 3;
	localparam int shiftSelW = 2;
	localparam int regSelW   = 2;
	localparam int memToRegW = 2;

endpackage

`default_nettype wire
